/* chain_pkg.sv */
`default_nettype none

// structure of the loader chain
package chain_pkg;

    // direction a shift register moves its words
    // SHIFT_TO_HIGH puts a new word at index 0 and moves older words up
    // SHIFT_TO_LOW puts a new word at the top index and moves older words down
    typedef enum logic
    {
        SHIFT_TO_HIGH = 1'b0,
        SHIFT_TO_LOW  = 1'b1
    } shift_dir_t;

    // middle hold registers between the two shift registers
    // at least one is needed
    localparam int DEF_MID_STAGES = 2;

    // with this direction words leave in the order they came in
    localparam shift_dir_t DEF_SHIFT_DIR = SHIFT_TO_HIGH;

endpackage

`default_nettype wire

/* filelist.f */
info_pkg.sv
chain_pkg.sv
info_shift_in.sv
info_stage_chain.sv
info_shift_out.sv
info_loader_chain.sv
info_loader_chain_chk.sv
tb_info_loader_chain.sv

/* info_loader_chain.sv */
`timescale 1ns/10ps
`default_nettype none

// serial in, serial out information loader chain
// input shift register -> middle hold stages -> output shift register
// no handshake, sequencing of the pulses is up to the caller
module info_loader_chain
#(
    parameter int                    MID_STAGES = chain_pkg::DEF_MID_STAGES,
    parameter chain_pkg::shift_dir_t SHIFT_DIR  = chain_pkg::DEF_SHIFT_DIR
)
(
    input  logic                   clk,
    input  logic                   rst,
    // global clock enable, low freezes every register
    input  logic                   en,

    // input loader shift pulse and word
    input  logic                   shift_in_en,
    input  info_pkg::info_t        info_in,

    // one init pulse per middle stage
    input  logic [MID_STAGES-1:0]  load_mid,

    // output loader init and shift pulses
    input  logic                   load_out,
    input  logic                   shift_out_en,
    input  logic                   out_en,

    output info_pkg::info_t        info_out
);

    // frame collected by the input loader
    info_pkg::frame_t frame_in_q;

    // last middle stage, source for the output loader
    info_pkg::frame_t frame_mid_q;

    // serial to parallel edge
    info_shift_in
    #(
        .SHIFT_DIR  (SHIFT_DIR)
    )
    u_shift_in
    (
        .clk        (clk),
        .rst        (rst),
        .en         (en),
        .shift_en   (shift_in_en),
        .info_in    (info_in),
        .frame      (frame_in_q)
    );

    // middle hold stages
    info_stage_chain
    #(
        .MID_STAGES (MID_STAGES)
    )
    u_stage_chain
    (
        .clk        (clk),
        .rst        (rst),
        .en         (en),
        .load       (load_mid),
        .frame_in   (frame_in_q),
        .frame_out  (frame_mid_q)
    );

    // parallel to serial edge with output gating
    info_shift_out
    #(
        .SHIFT_DIR  (SHIFT_DIR)
    )
    u_shift_out
    (
        .clk        (clk),
        .rst        (rst),
        .en         (en),
        .load       (load_out),
        .shift_en   (shift_out_en),
        .out_en     (out_en),
        .frame_in   (frame_mid_q),
        .info_out   (info_out)
    );

endmodule

`default_nettype wire

/* info_loader_chain_chk.sv */
`timescale 1ns/10ps
`default_nettype none

// checks on the loader chain top level
module info_loader_chain_chk
(
    input logic              clk,
    input logic              rst,
    input logic              en,
    input logic              out_en,
    input info_pkg::info_t   info_out,
    input info_pkg::frame_t  frame_in_q
);

    // all registers clear, so output reads zero
    a_reset_zero : assert property (@(posedge clk) rst |=> info_out == '0)
        else $error("info_out not zero in the cycle after reset");

    // gating forces zero whatever the output loader holds
    a_gate_zero : assert property (@(posedge clk) disable iff (rst) !out_en |-> info_out == '0)
        else $error("info_out not zero while out_en is low");

    // frozen input loader
    a_en_hold : assert property (@(posedge clk) disable iff (rst) !en |=> $stable(frame_in_q))
        else $error("frame_in_q changed while en was low");

endmodule

bind info_loader_chain info_loader_chain_chk u_chk
(
    .clk        (clk),
    .rst        (rst),
    .en         (en),
    .out_en     (out_en),
    .info_out   (info_out),
    .frame_in_q (frame_in_q)
);

`default_nettype wire

/* info_pkg.sv */
`default_nettype none

// data description shared by every loader
package info_pkg;

    // width of one information word
    localparam int INFO_BITS = 8;

    // words gathered into one frame
    localparam int INFO_NUMS = 4;

    // a single word on the serial side
    typedef logic [INFO_BITS-1:0] info_t;

    // one frame, word 0 in the low bits
    // index order is what the shift direction works on
    typedef info_t [INFO_NUMS-1:0] frame_t;

endpackage

`default_nettype wire

/* info_shift_in.sv */
`timescale 1ns/10ps
`default_nettype none

// serial to parallel loader
// gathers INFO_NUMS words into one frame, one word per shift pulse
module info_shift_in
#(
    parameter chain_pkg::shift_dir_t SHIFT_DIR = chain_pkg::DEF_SHIFT_DIR
)
(
    input  logic              clk,
    input  logic              rst,
    input  logic              en,
    input  logic              shift_en,
    input  info_pkg::info_t   info_in,
    output info_pkg::frame_t  frame
);

    // frame after one shift, new word pushed in at the entry end
    info_pkg::frame_t frame_shifted;

    always_comb
    begin
        frame_shifted = frame;
        if (SHIFT_DIR == chain_pkg::SHIFT_TO_HIGH)
        begin
            // older words move up, oldest lands at the top index
            for (int i = info_pkg::INFO_NUMS - 1; i > 0; i--)
            begin
                frame_shifted[i] = frame[i-1];
            end
            frame_shifted[0] = info_in;
        end
        else
        begin
            // mirror case, oldest lands at index 0
            for (int i = 0; i < info_pkg::INFO_NUMS - 1; i++)
            begin
                frame_shifted[i] = frame[i+1];
            end
            frame_shifted[info_pkg::INFO_NUMS-1] = info_in;
        end
    end

    // frame register
    // word shows up one cycle after its shift pulse
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            frame <= '0;
        end
        else if (en && shift_en)
        begin
            frame <= frame_shifted;
        end
    end

endmodule

`default_nettype wire

/* info_shift_out.sv */
`timescale 1ns/10ps
`default_nettype none

// parallel to serial loader
// loads a whole frame, then emits it one word per shift pulse
module info_shift_out
#(
    parameter chain_pkg::shift_dir_t SHIFT_DIR = chain_pkg::DEF_SHIFT_DIR
)
(
    input  logic              clk,
    input  logic              rst,
    input  logic              en,
    input  logic              load,
    input  logic              shift_en,
    input  logic              out_en,
    input  info_pkg::frame_t  frame_in,
    output info_pkg::info_t   info_out
);

    // output position, the far end from where words would enter
    localparam int OUT_IDX =
        (SHIFT_DIR == chain_pkg::SHIFT_TO_HIGH) ? info_pkg::INFO_NUMS - 1 : 0;

    // frame register
    info_pkg::frame_t frame_q;

    // frame after one shift with a zero word filling in behind
    info_pkg::frame_t frame_shifted;

    always_comb
    begin
        frame_shifted = frame_q;
        if (SHIFT_DIR == chain_pkg::SHIFT_TO_HIGH)
        begin
            // next word moves up into the top index
            for (int i = info_pkg::INFO_NUMS - 1; i > 0; i--)
            begin
                frame_shifted[i] = frame_q[i-1];
            end
            frame_shifted[0] = '0;
        end
        else
        begin
            // next word moves down into index 0
            for (int i = 0; i < info_pkg::INFO_NUMS - 1; i++)
            begin
                frame_shifted[i] = frame_q[i+1];
            end
            frame_shifted[info_pkg::INFO_NUMS-1] = '0;
        end
    end

    // load wins over shift
    // a full drain leaves an all zero frame
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            frame_q <= '0;
        end
        else if (en)
        begin
            if (load)
            begin
                frame_q <= frame_in;
            end
            else if (shift_en)
            begin
                frame_q <= frame_shifted;
            end
        end
    end

    // combinational from the output position
    // forced to zero while out_en is low
    assign info_out = out_en ? frame_q[OUT_IDX] : '0;

endmodule

`default_nettype wire

/* info_stage_chain.sv */
`timescale 1ns/10ps
`default_nettype none

// middle hold registers between the two shift registers
// each stage has its own init pulse so several frames can be in flight
module info_stage_chain
#(
    // must be 1 or more
    parameter int MID_STAGES = chain_pkg::DEF_MID_STAGES
)
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   en,
    input  logic [MID_STAGES-1:0]  load,
    input  info_pkg::frame_t       frame_in,
    output info_pkg::frame_t       frame_out
);

    // stage boundaries
    // entry 0 is the chain input, entry s+1 is the output of stage s
    wire info_pkg::frame_t link [MID_STAGES+1];

    assign link[0] = frame_in;

    for (genvar s = 0; s < MID_STAGES; s++)
    begin : g_stage
        // hold register of this stage
        info_pkg::frame_t stage_q;

        // takes whatever the previous stage holds this cycle
        // so the caller pulses from last stage to first to move frames forward
        always_ff @(posedge clk)
        begin
            if (rst)
            begin
                stage_q <= '0;
            end
            else if (en && load[s])
            begin
                stage_q <= link[s];
            end
        end

        assign link[s+1] = stage_q;
    end

    // last stage feeds the output loader
    assign frame_out = link[MID_STAGES];

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the loader chain testbench with Verilator
# exit status is nonzero when the testbench fails
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_info_loader_chain \
    -f filelist.f \
    -o sim_tb

./obj_dir/sim_tb

/* tb_info_loader_chain.sv */
`timescale 1ns/10ps
`default_nettype none

// table driven testbench for the loader chain
// each pass shifts a frame in, advances the middle stages, loads out and drains
module tb_info_loader_chain;

    localparam int MID_STAGES     = chain_pkg::DEF_MID_STAGES;
    localparam int INFO_NUMS      = info_pkg::INFO_NUMS;
    localparam int NUM_ROWS       = 8;
    localparam int STALL_CYCLES   = 3;
    // extra passes push the last frames out of the middle stages
    localparam int NUM_PASSES     = NUM_ROWS + MID_STAGES - 1;
    localparam int CYCLES_PER_ROW = STALL_CYCLES + 2 * INFO_NUMS + MID_STAGES + 3;
    localparam int TIMEOUT_CYCLES = 2 * NUM_PASSES * CYCLES_PER_ROW;

    logic                   clk;
    logic                   rst;
    logic                   en;
    logic                   shift_in_en;
    info_pkg::info_t        info_in;
    logic [MID_STAGES-1:0]  load_mid;
    logic                   load_out;
    logic                   shift_out_en;
    logic                   out_en;
    info_pkg::info_t        info_out;

    // stimulus words with out_en and stall flag per row
    info_pkg::info_t        tbl_words  [NUM_ROWS][INFO_NUMS];
    logic                   tbl_out_en [NUM_ROWS];
    logic                   tbl_stall  [NUM_ROWS];
    // expected words per row
    // last entry is the drained output
    info_pkg::info_t        tbl_expect [NUM_ROWS][INFO_NUMS+1];

    int                     cycle_cnt = 0;

    info_loader_chain UUT
    (
        .clk          (clk),
        .rst          (rst),
        .en           (en),
        .shift_in_en  (shift_in_en),
        .info_in      (info_in),
        .load_mid     (load_mid),
        .load_out     (load_out),
        .shift_out_en (shift_out_en),
        .out_en       (out_en),
        .info_out     (info_out)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // run length guard
    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTBENCH FAILED");
            $fatal(1, "run stopped by timeout");
        end
    end

    task automatic check_info(input info_pkg::info_t expected, input info_pkg::info_t actual);
        if (actual !== expected)
        begin
            $display("Fail at %0t: info_out expected %h, got %h", $time, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "info_out mismatch");
        end
    endtask

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic fill_table();
        for (int r = 0; r < NUM_ROWS; r++)
        begin
            // every third row gated, some rows stalled
            tbl_out_en[r] = (r % 3 != 2);
            tbl_stall[r]  = (r % 4 == 1);
            for (int i = 0; i < INFO_NUMS; i++)
            begin
                tbl_words[r][i]  = info_pkg::info_t'($urandom);
                // same order out as in, zero while gated
                tbl_expect[r][i] = tbl_out_en[r] ? tbl_words[r][i] : '0;
            end
            // zero words fill in behind
            tbl_expect[r][INFO_NUMS] = '0;
        end
    endtask

    // en low with every pulse driven
    // output loader is drained so info_out stays zero
    task automatic stall_chain();
        en           = 1'b0;
        shift_in_en  = 1'b1;
        load_mid     = '1;
        load_out     = 1'b1;
        shift_out_en = 1'b1;
        out_en       = 1'b1;
        for (int c = 0; c < STALL_CYCLES; c++)
        begin
            info_in = info_pkg::info_t'($urandom);
            @(negedge clk);
            check_info('0, info_out);
            next_cycle();
        end
        shift_in_en  = 1'b0;
        load_mid     = '0;
        load_out     = 1'b0;
        shift_out_en = 1'b0;
        info_in      = '0;
        en           = 1'b1;
    endtask

    task automatic shift_in_frame(input int row);
        for (int i = 0; i < INFO_NUMS; i++)
        begin
            shift_in_en = 1'b1;
            info_in     = tbl_words[row][i];
            next_cycle();
        end
        shift_in_en = 1'b0;
        info_in     = '0;
    endtask

    // last stage first so nothing is overwritten
    task automatic advance_mid();
        for (int s = MID_STAGES - 1; s >= 0; s--)
        begin
            load_mid    = '0;
            load_mid[s] = 1'b1;
            next_cycle();
        end
        load_mid = '0;
    endtask

    task automatic load_output();
        load_out = 1'b1;
        next_cycle();
        load_out = 1'b0;
    endtask

    // one word per shift, then the drained zero with out_en forced high
    task automatic emit_and_check(input int row);
        for (int i = 0; i <= INFO_NUMS; i++)
        begin
            out_en       = (i == INFO_NUMS) ? 1'b1 : tbl_out_en[row];
            shift_out_en = 1'b1;
            @(negedge clk);
            check_info(tbl_expect[row][i], info_out);
            next_cycle();
        end
        shift_out_en = 1'b0;
        out_en       = 1'b1;
    endtask

    initial
    begin
        rst          = 1'b1;
        en           = 1'b1;
        shift_in_en  = 1'b0;
        info_in      = '0;
        load_mid     = '0;
        load_out     = 1'b0;
        shift_out_en = 1'b0;
        out_en       = 1'b0;

        void'($urandom(32'h8ffe_2b57));
        fill_table();

        repeat (3) @(posedge clk);
        #1;
        rst    = 1'b0;
        out_en = 1'b1;
        // nothing loaded yet
        @(negedge clk);
        check_info('0, info_out);
        next_cycle();

        // frame p-(MID_STAGES-1) leaves while frame p waits in stage 0
        for (int p = 0; p < NUM_PASSES; p++)
        begin
            if (p < NUM_ROWS)
            begin
                shift_in_frame(p);
                // stall while frames sit in the input loader and the middle stages
                if (tbl_stall[p])
                begin
                    stall_chain();
                end
            end
            advance_mid();
            if (p >= MID_STAGES - 1)
            begin
                load_output();
                emit_and_check(p - (MID_STAGES - 1));
            end
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire
